/* hdl/tcdm_consts.svh */
// Sizes, address fields and atomic opcodes of the shared L1 memory path.
// Include wherever a width, count or atop code is needed.

`ifndef TCDM_CONSTS_SVH
`define TCDM_CONSTS_SVH

// port and bank counts
`define TCDM_NUM_MASTERS     3
`define TCDM_NUM_BANKS       4
`define TCDM_MASTER_ID_BITS  2
`define TCDM_BANK_SEL_BITS   2

// data path
`define TCDM_DATA_WIDTH      32
`define TCDM_ADDR_WIDTH      32
`define TCDM_ATOP_WIDTH      6

// byte address fields: [1:0] byte, [3:2] bank, [11:4] row
`define TCDM_BYTE_OFF_BITS   2
`define TCDM_BANK_DEPTH_LOG2 8
`define TCDM_BANK_LSB        `TCDM_BYTE_OFF_BITS
`define TCDM_ROW_LSB         (`TCDM_BYTE_OFF_BITS + `TCDM_BANK_SEL_BITS)

// risc-v amo funct5 with bit 5 as the valid flag
`define TCDM_ATOP_ADD        6'h20
`define TCDM_ATOP_SWAP       6'h21
`define TCDM_ATOP_XOR        6'h24
`define TCDM_ATOP_OR         6'h28
`define TCDM_ATOP_AND        6'h2C
`define TCDM_ATOP_MIN        6'h30
`define TCDM_ATOP_MAX        6'h34
`define TCDM_ATOP_MINU       6'h38
`define TCDM_ATOP_MAXU       6'h3C

`endif

/* hdl/tcdm_pkg.sv */
// Types shared by the crossbar, AMO shims, banks and response router.
// Import with a wildcard in the module header.

`include "tcdm_consts.svh"

package tcdm_pkg;

  typedef logic [`TCDM_DATA_WIDTH-1:0]      word_t;
  typedef logic [`TCDM_DATA_WIDTH/8-1:0]    byte_en_t;
  typedef logic [`TCDM_ADDR_WIDTH-1:0]      addr_t;
  typedef logic [`TCDM_BANK_DEPTH_LOG2-1:0] row_addr_t;
  typedef logic [`TCDM_BANK_SEL_BITS-1:0]   bank_sel_t;
  typedef logic [`TCDM_MASTER_ID_BITS-1:0]  master_id_t;
  typedef logic [`TCDM_ATOP_WIDTH-1:0]      atop_t;

  // core side request, wen high means write
  typedef struct packed {
    logic     req;
    addr_t    addr;
    logic     wen;
    byte_en_t be;
    word_t    wdata;
    atop_t    atop;
  } master_req_t;

  typedef struct packed {
    logic  rvalid;
    word_t rdata;
  } master_rsp_t;

  // granted request, one lane per bank
  typedef struct packed {
    logic       valid;
    master_id_t master_id;
    row_addr_t  row;
    logic       wen;
    byte_en_t   be;
    word_t      wdata;
    atop_t      atop;
  } bank_req_t;

  // sram command
  typedef struct packed {
    logic      en;
    logic      we;
    row_addr_t row;
    byte_en_t  be;
    word_t     wdata;
  } mem_req_t;

  typedef enum logic {
    SHIM_IDLE,
    SHIM_WRITEBACK
  } shim_state_e;

endpackage

/* hdl/tcdm_crossbar.sv */
// Master to bank crossbar with one round-robin arbiter per bank.
// Grants are combinational; a bank that is not ready grants nothing.

`include "tcdm_consts.svh"

module tcdm_crossbar import tcdm_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  master_req_t [`TCDM_NUM_MASTERS-1:0]  req_i,
  input  logic        [`TCDM_NUM_BANKS-1:0]    bank_ready_i,
  output logic        [`TCDM_NUM_MASTERS-1:0]  gnt_o,
  output bank_req_t   [`TCDM_NUM_BANKS-1:0]    bank_req_o
);

  bank_sel_t  [`TCDM_NUM_MASTERS-1:0] bank_sel;
  master_id_t [`TCDM_NUM_BANKS-1:0]   rr_q;
  master_id_t [`TCDM_NUM_BANKS-1:0]   rr_d;
  master_id_t [`TCDM_NUM_BANKS-1:0]   winner;
  logic       [`TCDM_NUM_BANKS-1:0]   win_valid;

  // word interleaved bank select
  always_comb begin : bank_decode
    for (int m = 0; m < `TCDM_NUM_MASTERS; m++) begin
      bank_sel[m] = req_i[m].addr[`TCDM_BANK_LSB +: `TCDM_BANK_SEL_BITS];
    end
  end

  // *************************************************************************
  // arbitration, first requester at or after the pointer wins
  // *************************************************************************
  always_comb begin : arbitrate
    int idx;
    for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
      winner[b]    = rr_q[b];
      win_valid[b] = 1'b0;
      for (int k = 0; k < `TCDM_NUM_MASTERS; k++) begin
        idx = int'(rr_q[b]) + k;
        if (idx >= `TCDM_NUM_MASTERS) begin
          idx = idx - `TCDM_NUM_MASTERS;
        end
        if (!win_valid[b] && req_i[idx].req && bank_sel[idx] == bank_sel_t'(b)) begin
          win_valid[b] = 1'b1;
          winner[b]    = master_id_t'(idx);
        end
      end
      // busy bank (atomic writeback) blocks the lane
      if (!bank_ready_i[b]) begin
        win_valid[b] = 1'b0;
      end
    end
  end

  // forward winner fields, grant it, advance the pointer
  always_comb begin : route
    gnt_o = '0;
    for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
      bank_req_o[b].valid     = win_valid[b];
      bank_req_o[b].master_id = winner[b];
      bank_req_o[b].row       = req_i[winner[b]].addr[`TCDM_ROW_LSB +: `TCDM_BANK_DEPTH_LOG2];
      bank_req_o[b].wen       = req_i[winner[b]].wen;
      bank_req_o[b].be        = req_i[winner[b]].be;
      bank_req_o[b].wdata     = req_i[winner[b]].wdata;
      bank_req_o[b].atop      = req_i[winner[b]].atop;
      rr_d[b] = rr_q[b];
      if (win_valid[b]) begin
        gnt_o[winner[b]] = 1'b1;
        if (winner[b] == master_id_t'(`TCDM_NUM_MASTERS - 1)) begin
          rr_d[b] = '0;
        end else begin
          rr_d[b] = winner[b] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : rr_ptr
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      rr_q <= rr_d;
    end
  end

endmodule

/* hdl/amo_shim.sv */
// Atomic memory operation shim in front of one bank.
// Plain accesses pass straight through; an atop becomes a read followed
// by a full word writeback one cycle later, during which ready is low.

`include "tcdm_consts.svh"

module amo_shim import tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  bank_req_t bank_req_i,
  output logic      ready_o,
  output mem_req_t  mem_req_o,
  input  word_t     mem_rdata_i,
  output word_t     rdata_o
);

  shim_state_e state_q;
  shim_state_e state_d;
  logic        is_amo;
  logic        amo_start;
  atop_t       atop_q;
  word_t       operand_q;
  row_addr_t   row_q;
  word_t       amo_result;

  // only listed codes count, others fall back to a plain read
  always_comb begin : atop_decode
    case (bank_req_i.atop)
      `TCDM_ATOP_ADD,
      `TCDM_ATOP_SWAP,
      `TCDM_ATOP_XOR,
      `TCDM_ATOP_OR,
      `TCDM_ATOP_AND,
      `TCDM_ATOP_MIN,
      `TCDM_ATOP_MAX,
      `TCDM_ATOP_MINU,
      `TCDM_ATOP_MAXU: is_amo = 1'b1;
      default:         is_amo = 1'b0;
    endcase
  end

  assign amo_start = (state_q == SHIM_IDLE) && bank_req_i.valid && is_amo;

  // *************************************************************************
  // alu, old word from the bank against the registered operand
  // *************************************************************************
  always_comb begin : amo_alu
    case (atop_q)
      `TCDM_ATOP_ADD:  amo_result = mem_rdata_i + operand_q;
      `TCDM_ATOP_SWAP: amo_result = operand_q;
      `TCDM_ATOP_XOR:  amo_result = mem_rdata_i ^ operand_q;
      `TCDM_ATOP_OR:   amo_result = mem_rdata_i | operand_q;
      `TCDM_ATOP_AND:  amo_result = mem_rdata_i & operand_q;
      `TCDM_ATOP_MIN: begin
        amo_result = ($signed(mem_rdata_i) < $signed(operand_q)) ? mem_rdata_i : operand_q;
      end
      `TCDM_ATOP_MAX: begin
        amo_result = ($signed(mem_rdata_i) > $signed(operand_q)) ? mem_rdata_i : operand_q;
      end
      `TCDM_ATOP_MINU: amo_result = (mem_rdata_i < operand_q) ? mem_rdata_i : operand_q;
      `TCDM_ATOP_MAXU: amo_result = (mem_rdata_i > operand_q) ? mem_rdata_i : operand_q;
      default:         amo_result = mem_rdata_i;
    endcase
  end

  // *************************************************************************
  // sequencing and bank command
  // *************************************************************************
  always_comb begin : shim_ctrl
    state_d   = state_q;
    mem_req_o = '0;
    case (state_q)
      SHIM_IDLE: begin
        mem_req_o.en    = bank_req_i.valid;
        // a valid atop never writes in its grant cycle
        mem_req_o.we    = bank_req_i.valid & bank_req_i.wen &
                          ~bank_req_i.atop[`TCDM_ATOP_WIDTH-1];
        mem_req_o.row   = bank_req_i.row;
        mem_req_o.be    = bank_req_i.be;
        mem_req_o.wdata = bank_req_i.wdata;
        if (amo_start) begin
          state_d = SHIM_WRITEBACK;
        end
      end
      SHIM_WRITEBACK: begin
        mem_req_o.en    = 1'b1;
        mem_req_o.we    = 1'b1;
        mem_req_o.row   = row_q;
        mem_req_o.be    = '1;
        mem_req_o.wdata = amo_result;
        state_d         = SHIM_IDLE;
      end
      default: state_d = SHIM_IDLE;
    endcase
  end

  assign ready_o = (state_q == SHIM_IDLE);
  assign rdata_o = mem_rdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= SHIM_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // operand capture for the writeback phase
  always_ff @(posedge clk_i) begin : amo_capture
    if (amo_start) begin
      atop_q    <= bank_req_i.atop;
      operand_q <= bank_req_i.wdata;
      row_q     <= bank_req_i.row;
    end
  end

endmodule

/* hdl/tcdm_bank.sv */
// One word-wide single-port bank with byte enables.
// Read data is registered and shows up the cycle after en.

`include "tcdm_consts.svh"

module tcdm_bank import tcdm_pkg::*; (
  input  logic     clk_i,
  input  mem_req_t mem_req_i,
  output word_t    rdata_o
);

  localparam int NumBytes = `TCDM_DATA_WIDTH / 8;

  word_t mem_q [2**`TCDM_BANK_DEPTH_LOG2];
  word_t rdata_q;

  // read returns the word as it was before a same-cycle write
  always_ff @(posedge clk_i) begin : mem_access
    if (mem_req_i.en) begin
      rdata_q <= mem_q[mem_req_i.row];
      if (mem_req_i.we) begin
        for (int i = 0; i < NumBytes; i++) begin
          if (mem_req_i.be[i]) begin
            mem_q[mem_req_i.row][i*8 +: 8] <= mem_req_i.wdata[i*8 +: 8];
          end
        end
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* hdl/response_router.sv */
// Returns each bank's read word to the master it served last cycle.
// rvalid follows the grant by exactly one cycle.

`include "tcdm_consts.svh"

module response_router import tcdm_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  bank_req_t   [`TCDM_NUM_BANKS-1:0]   bank_req_i,
  input  word_t       [`TCDM_NUM_BANKS-1:0]   bank_rdata_i,
  output master_rsp_t [`TCDM_NUM_MASTERS-1:0] rsp_o
);

  logic       [`TCDM_NUM_BANKS-1:0] valid_q;
  master_id_t [`TCDM_NUM_BANKS-1:0] id_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_reg
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
        valid_q[b] <= bank_req_i[b].valid;
      end
    end
  end

  always_ff @(posedge clk_i) begin : id_reg
    for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
      id_q[b] <= bank_req_i[b].master_id;
    end
  end

  // a master wins at most one bank per cycle, so no two hits collide
  always_comb begin : route_back
    rsp_o = '0;
    for (int m = 0; m < `TCDM_NUM_MASTERS; m++) begin
      for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
        if (valid_q[b] && id_q[b] == master_id_t'(m)) begin
          rsp_o[m].rvalid = 1'b1;
          rsp_o[m].rdata  = bank_rdata_i[b];
        end
      end
    end
  end

endmodule

/* hdl/tcdm_interconnect_top.sv */
// Top of the shared L1 path: crossbar, per-bank AMO shim and bank,
// then the response router back to the masters.

`include "tcdm_consts.svh"

module tcdm_interconnect_top import tcdm_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  master_req_t [`TCDM_NUM_MASTERS-1:0] req_i,
  output logic        [`TCDM_NUM_MASTERS-1:0] gnt_o,
  output master_rsp_t [`TCDM_NUM_MASTERS-1:0] rsp_o
);

  bank_req_t [`TCDM_NUM_BANKS-1:0] bank_req;
  logic      [`TCDM_NUM_BANKS-1:0] bank_ready;
  mem_req_t  [`TCDM_NUM_BANKS-1:0] mem_req;
  word_t     [`TCDM_NUM_BANKS-1:0] mem_rdata;
  word_t     [`TCDM_NUM_BANKS-1:0] bank_rdata;

  tcdm_crossbar i_tcdm_crossbar (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .req_i        ( req_i      ),
    .bank_ready_i ( bank_ready ),
    .gnt_o        ( gnt_o      ),
    .bank_req_o   ( bank_req   )
  );

  // *************************************************************************
  // one shim and one sram per bank
  // *************************************************************************
  for (genvar b = 0; b < `TCDM_NUM_BANKS; b++) begin : gen_bank
    amo_shim i_amo_shim (
      .clk_i       ( clk_i         ),
      .rst_ni      ( rst_ni        ),
      .bank_req_i  ( bank_req[b]   ),
      .ready_o     ( bank_ready[b] ),
      .mem_req_o   ( mem_req[b]    ),
      .mem_rdata_i ( mem_rdata[b]  ),
      .rdata_o     ( bank_rdata[b] )
    );

    tcdm_bank i_tcdm_bank (
      .clk_i     ( clk_i        ),
      .mem_req_i ( mem_req[b]   ),
      .rdata_o   ( mem_rdata[b] )
    );
  end

  response_router i_response_router (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .bank_req_i   ( bank_req   ),
    .bank_rdata_i ( bank_rdata ),
    .rsp_o        ( rsp_o      )
  );

endmodule

/* test/tb_tasks.svh */
// Directed tests and compare tasks for the interconnect testbench.
// Included inside the testbench module, so it uses its signals directly.

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

  task automatic compare_word(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_gnt(input string what, input gnt_vec_t got, input gnt_vec_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s: gnt %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic compare_valid(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s: rvalid %b, expected %b", $time, what, got, exp);
    end
  endtask

  // **************************************************************************
  // stimulus helpers
  // **************************************************************************

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  function automatic master_req_t make_req(addr_t addr, logic wen, byte_en_t be,
                                           word_t wdata, atop_t atop);
    master_req_t r;
    r.req   = 1'b1;
    r.addr  = addr;
    r.wen   = wen;
    r.be    = be;
    r.wdata = wdata;
    r.atop  = atop;
    return r;
  endfunction

  // gnt is combinational and is sampled a quarter period after driving
  task automatic wait_grant(input int m);
    #(QUARTER);
    while (!gnt[m]) begin
      @(negedge clk_i);
      #(QUARTER);
    end
  endtask

  // one request of master m with its response one cycle after gnt
  task automatic single_access(input int m, input addr_t addr, input logic wen,
                               input byte_en_t be, input word_t wdata,
                               input atop_t atop, output word_t rdata);
    @(negedge clk_i);
    mst_req[m] = make_req(addr, wen, be, wdata, atop);
    wait_grant(m);
    compare_valid("no rvalid in the gnt cycle", rsp[m].rvalid, 1'b0);
    @(negedge clk_i);
    compare_valid("rvalid one cycle after gnt", rsp[m].rvalid, 1'b1);
    rdata = rsp[m].rdata;
    mst_req[m].req = 1'b0;
  endtask

  task automatic write_word(input int m, input addr_t addr, input byte_en_t be,
                            input word_t data);
    word_t unused;
    single_access(m, addr, 1'b1, be, data, '0, unused);
    ref_write(addr, be, data);
  endtask

  task automatic read_check(input int m, input addr_t addr, input string what);
    word_t got;
    single_access(m, addr, 1'b0, '1, '0, '0, got);
    compare_word(what, got, ref_mem[ref_index(addr)]);
  endtask

  // **************************************************************************
  // directed tests
  // **************************************************************************

  task automatic test_write_read();
    row_addr_t rows [3];
    rows = '{8'd0, 8'd255, row_addr_t'($urandom)};
    for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
      for (int r = 0; r < 3; r++) begin
        write_word(0, make_addr(bank_sel_t'(b), rows[r]), '1, $urandom);
      end
    end
    // read back through fresh addresses with other upper bits
    for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
      for (int r = 0; r < 3; r++) begin
        read_check(0, make_addr(bank_sel_t'(b), rows[r]), "write then read");
      end
    end
  endtask

  task automatic test_byte_enables();
    addr_t    addr;
    byte_en_t patterns [8];
    patterns = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h5, 4'hA, 4'h3, 4'h0};
    addr     = make_addr(2'd1, 8'd10);
    write_word(2, addr, '1, $urandom);
    foreach (patterns[i]) begin
      write_word(2, addr, patterns[i], $urandom);
      read_check(2, addr, $sformatf("byte enables %h", patterns[i]));
    end
  endtask

  task automatic test_parallel_banks();
    addr_t addr [`TCDM_NUM_MASTERS];
    for (int m = 0; m < `TCDM_NUM_MASTERS; m++) begin
      addr[m] = make_addr(bank_sel_t'(m + 1), row_addr_t'(20 + m));
      write_word(m, addr[m], '1, $urandom);
    end
    @(negedge clk_i);
    for (int m = 0; m < `TCDM_NUM_MASTERS; m++) begin
      mst_req[m] = make_req(addr[m], 1'b0, '1, '0, '0);
    end
    #(QUARTER);
    compare_gnt("parallel grant", gnt, '1);
    @(negedge clk_i);
    for (int m = 0; m < `TCDM_NUM_MASTERS; m++) begin
      compare_valid("parallel rvalid", rsp[m].rvalid, 1'b1);
      compare_word("parallel read", rsp[m].rdata, ref_mem[ref_index(addr[m])]);
    end
    mst_req = '0;
  endtask

  // the reset puts the pointers back at master 0 so grants go 0 then 1 then 2
  task automatic test_bank_conflict();
    addr_t    addr [`TCDM_NUM_MASTERS];
    gnt_vec_t g;
    for (int m = 0; m < `TCDM_NUM_MASTERS; m++) begin
      addr[m] = make_addr(2'd2, row_addr_t'(32 + m));
      write_word(0, addr[m], '1, $urandom);
    end
    apply_reset();
    @(negedge clk_i);
    for (int m = 0; m < `TCDM_NUM_MASTERS; m++) begin
      mst_req[m] = make_req(addr[m], 1'b0, '1, '0, '0);
    end
    for (int c = 0; c < `TCDM_NUM_MASTERS; c++) begin
      #(QUARTER);
      g = gnt;
      compare_gnt("conflict grant", g, gnt_vec_t'(1 << c));
      @(negedge clk_i);
      for (int m = 0; m < `TCDM_NUM_MASTERS; m++) begin
        if (g[m]) begin
          compare_valid("conflict rvalid", rsp[m].rvalid, 1'b1);
          compare_word("conflict read", rsp[m].rdata, ref_mem[ref_index(addr[m])]);
          mst_req[m].req = 1'b0;
        end
      end
    end
    mst_req = '0;
  endtask

  task automatic test_atomics();
    atop_t ops   [9];
    word_t olds  [3];
    word_t opnds [3];
    addr_t addr;
    word_t got;
    ops = '{`TCDM_ATOP_ADD, `TCDM_ATOP_SWAP, `TCDM_ATOP_XOR, `TCDM_ATOP_OR,
            `TCDM_ATOP_AND, `TCDM_ATOP_MIN, `TCDM_ATOP_MAX, `TCDM_ATOP_MINU,
            `TCDM_ATOP_MAXU};
    for (int i = 0; i < 9; i++) begin
      // random pair, then negative against positive, then the signed extremes
      olds  = '{word_t'($urandom), 32'hFFFF_FFF0, 32'h8000_0000};
      opnds = '{word_t'($urandom), 32'h0000_0010, 32'h7FFF_FFFF};
      addr  = make_addr(bank_sel_t'(i % `TCDM_NUM_BANKS), row_addr_t'(64 + i));
      for (int k = 0; k < 3; k++) begin
        write_word(i % `TCDM_NUM_MASTERS, addr, '1, olds[k]);
        single_access(i % `TCDM_NUM_MASTERS, addr, 1'b1, '1, opnds[k], ops[i], got);
        compare_word($sformatf("atop %h old word", ops[i]), got, olds[k]);
        ref_mem[ref_index(addr)] = amo_ref(ops[i], olds[k], opnds[k]);
        read_check(i % `TCDM_NUM_MASTERS, addr, $sformatf("atop %h result", ops[i]));
      end
    end
  endtask

  task automatic test_amo_blocking();
    addr_t a_amo;
    addr_t a_same;
    addr_t a_other;
    word_t old;
    word_t opnd;
    a_amo   = make_addr(2'd0, 8'd96);
    a_same  = make_addr(2'd0, 8'd97);
    a_other = make_addr(2'd1, 8'd98);
    write_word(1, a_amo, '1, $urandom);
    write_word(1, a_same, '1, $urandom);
    write_word(1, a_other, '1, $urandom);
    old  = ref_mem[ref_index(a_amo)];
    opnd = $urandom;
    @(negedge clk_i);
    mst_req[0] = make_req(a_amo, 1'b1, '1, opnd, `TCDM_ATOP_ADD);
    #(QUARTER);
    compare_gnt("atomic grant", gnt, 3'b001);
    @(negedge clk_i);
    compare_valid("atomic rvalid", rsp[0].rvalid, 1'b1);
    compare_word("atomic old word", rsp[0].rdata, old);
    ref_mem[ref_index(a_amo)] = amo_ref(`TCDM_ATOP_ADD, old, opnd);
    mst_req[0].req = 1'b0;
    mst_req[1]     = make_req(a_same, 1'b0, '1, '0, '0);
    mst_req[2]     = make_req(a_other, 1'b0, '1, '0, '0);
    // bank 0 is writing back so only the other bank may grant
    #(QUARTER);
    compare_gnt("grant during writeback", gnt, 3'b100);
    @(negedge clk_i);
    compare_valid("other bank rvalid", rsp[2].rvalid, 1'b1);
    compare_word("other bank read", rsp[2].rdata, ref_mem[ref_index(a_other)]);
    mst_req[2].req = 1'b0;
    #(QUARTER);
    compare_gnt("grant after writeback", gnt, 3'b010);
    @(negedge clk_i);
    compare_valid("blocked master rvalid", rsp[1].rvalid, 1'b1);
    compare_word("blocked master read", rsp[1].rdata, ref_mem[ref_index(a_same)]);
    mst_req = '0;
    read_check(2, a_amo, "atomic result after blocking");
  endtask

`endif

/* test/tb_tcdm_interconnect.sv */
// Testbench for the shared L1 interconnect. Drives three masters through
// directed tests and checks every response against a reference memory.
// The test tasks themselves come from the included task file.

`include "tcdm_consts.svh"

module tb_tcdm_interconnect import tcdm_pkg::*; ();

  localparam int CLK_PERIOD     = 40;
  localparam int QUARTER        = CLK_PERIOD / 4;
  // the tests take roughly 300 cycles, so this leaves a wide margin
  localparam int TIMEOUT_CYCLES = 2000;

  typedef logic [`TCDM_NUM_MASTERS-1:0] gnt_vec_t;

  logic                                clk_i;
  logic                                rst_ni;
  master_req_t [`TCDM_NUM_MASTERS-1:0] mst_req;
  gnt_vec_t                            gnt;
  master_rsp_t [`TCDM_NUM_MASTERS-1:0] rsp;

  // one entry per word, indexed by address bits 11:2
  word_t ref_mem [`TCDM_NUM_BANKS << `TCDM_BANK_DEPTH_LOG2];
  int    cycles = 0;
  int    checks = 0;
  int    errors = 0;

  tcdm_interconnect_top i_tcdm_interconnect_top (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .req_i  ( mst_req ),
    .gnt_o  ( gnt     ),
    .rsp_o  ( rsp     )
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // **************************************************************************
  // reference model
  // **************************************************************************

  // byte offset and upper bits are random, the design must ignore them
  function automatic addr_t make_addr(bank_sel_t bank, row_addr_t row);
    addr_t addr;
    addr = addr_t'($urandom);
    addr[`TCDM_BANK_LSB +: `TCDM_BANK_SEL_BITS]  = bank;
    addr[`TCDM_ROW_LSB +: `TCDM_BANK_DEPTH_LOG2] = row;
    return addr;
  endfunction

  function automatic int ref_index(addr_t addr);
    return int'(addr[`TCDM_ROW_LSB + `TCDM_BANK_DEPTH_LOG2 - 1 : `TCDM_BANK_LSB]);
  endfunction

  function automatic void ref_write(addr_t addr, byte_en_t be, word_t data);
    int idx;
    idx = ref_index(addr);
    for (int i = 0; i < `TCDM_DATA_WIDTH / 8; i++) begin
      if (be[i]) begin
        ref_mem[idx][i*8 +: 8] = data[i*8 +: 8];
      end
    end
  endfunction

  // new memory word after an atomic, from the risc-v amo definitions
  function automatic word_t amo_ref(atop_t op, word_t old, word_t opnd);
    logic signed [`TCDM_DATA_WIDTH-1:0] s_old;
    logic signed [`TCDM_DATA_WIDTH-1:0] s_opnd;
    s_old  = old;
    s_opnd = opnd;
    case (op)
      `TCDM_ATOP_ADD:  return old + opnd;
      `TCDM_ATOP_SWAP: return opnd;
      `TCDM_ATOP_XOR:  return old ^ opnd;
      `TCDM_ATOP_OR:   return old | opnd;
      `TCDM_ATOP_AND:  return old & opnd;
      `TCDM_ATOP_MIN:  return (s_opnd < s_old) ? opnd : old;
      `TCDM_ATOP_MAX:  return (s_opnd > s_old) ? opnd : old;
      `TCDM_ATOP_MINU: return (opnd < old) ? opnd : old;
      `TCDM_ATOP_MAXU: return (opnd > old) ? opnd : old;
      default:         return old;
    endcase
  endfunction

  `include "tb_tasks.svh"

  initial begin : main
    void'($urandom(53));
    rst_ni  = 1'b0;
    mst_req = '0;
    apply_reset();
    test_write_read();
    test_byte_enables();
    test_parallel_banks();
    test_bank_conflict();
    test_atomics();
    test_amo_blocking();
    repeat (2) @(negedge clk_i);
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+hdl
+incdir+test
hdl/tcdm_pkg.sv
hdl/tcdm_crossbar.sv
hdl/amo_shim.sv
hdl/tcdm_bank.sv
hdl/response_router.sv
hdl/tcdm_interconnect_top.sv
test/tb_tcdm_interconnect.sv

/* run.sh */
#!/bin/sh
# build the interconnect testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f project.f \
  --top-module tb_tcdm_interconnect -o tb_tcdm_interconnect
./obj_dir/tb_tcdm_interconnect | tee sim.log

if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
